//--- design/word_pkg.sv
// Link word layout shared by the datapath
// Width of a word and the positions of its routing bits
package word_pkg;

	// Six-bit link word
	localparam int WORD_W = 6;

	// Virtual channel select
	// 0 goes to VC0, 1 goes to VC1
	localparam int VC_BIT = 5;

	// Destination select
	// 0 goes to D0, 1 goes to D1
	localparam int DST_BIT = 4;

	// Bits 3..0 are payload, never decoded here

endpackage

//--- design/ctrl_pkg.sv
// Control definitions for the link
// State codes, pause threshold width and watched FIFO count
package ctrl_pkg;

	// Pause threshold width, enough for a 16-deep FIFO
	localparam int THR_W = 4;

	// Main, VC0, VC1, D0, D1
	localparam int NUM_FIFOS = 5;

	// Control machine state encoding
	localparam int ST_W = 3;
	localparam logic [ST_W-1:0] ST_RESET  = 3'd0;
	localparam logic [ST_W-1:0] ST_INIT   = 3'd1;
	localparam logic [ST_W-1:0] ST_IDLE   = 3'd2;
	localparam logic [ST_W-1:0] ST_ACTIVE = 3'd3;
	localparam logic [ST_W-1:0] ST_ERROR  = 3'd4;

endpackage

//--- design/sync_fifo.sv
// Synchronous FIFO with registered read port
// Raises pause near full and flags pushes that overflow
`timescale 1ns/1ps

module sync_fifo #(
	parameter int DEPTH = 4
) (
	input  logic                        clk,
	input  logic                        reset_L,
	input  logic                        push,
	input  logic                        pop,
	input  logic [word_pkg::WORD_W-1:0] wr_data,
	input  logic [ctrl_pkg::THR_W-1:0]  thr,
	output logic [word_pkg::WORD_W-1:0] rd_data,
	output logic                        rd_valid,
	output logic                        pause,
	output logic                        full,
	output logic                        empty,
	output logic                        error
);
	import word_pkg::*;
	import ctrl_pkg::*;

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);
	// Room for count plus threshold without wrap
	localparam int SUM_W = ((CNT_W > THR_W) ? CNT_W : THR_W) + 1;

	logic [WORD_W-1:0] mem [DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [CNT_W-1:0]  count;
	logic              do_push;
	logic              do_pop;
	logic [SUM_W-1:0]  fill_sum;

	// Pointer advance with wrap at DEPTH
	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	// Levels straight from the count
	assign full  = (count == CNT_W'(DEPTH));
	assign empty = (count == '0);

	// Pop frees the head slot in the same cycle
	// so a push while full still fits when paired with a pop
	assign do_pop  = pop && !empty;
	assign do_push = push && (!full || do_pop);

	// count >= DEPTH - thr, rearranged to avoid underflow
	assign fill_sum = SUM_W'(count) + SUM_W'(thr);
	assign pause    = (fill_sum >= SUM_W'(DEPTH));

	// Pointers, count and strobes
	always_ff @(posedge clk) begin
		if (!reset_L) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			rd_valid <= 1'b0;
			error    <= 1'b0;
		end else begin
			rd_valid <= do_pop;
			// Dropped word, one-cycle flag
			error <= push && full && !do_pop;
			if (do_push)
				wr_ptr <= ptr_next(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_next(rd_ptr);
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Storage and registered head word
	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= wr_data;
		if (do_pop)
			rd_data <= mem[rd_ptr];
	end

endmodule

//--- design/vc_ingress.sv
// Ingress stage between main FIFO and the VC FIFOs
// Pops the main FIFO and steers each word by its VC bit
`timescale 1ns/1ps

module vc_ingress (
	input  logic                        clk,
	input  logic                        reset_L,
	input  logic                        main_empty,
	input  logic [word_pkg::WORD_W-1:0] main_rd_data,
	input  logic                        main_rd_valid,
	input  logic                        pause_vc0,
	input  logic                        pause_vc1,
	output logic                        main_pop,
	output logic                        vc0_push,
	output logic                        vc1_push,
	output logic [word_pkg::WORD_W-1:0] vc_data
);
	import word_pkg::*;

	logic vc_sel;

	// Pop decision taken at the edge
	// Either VC pause stops the stage, the threshold covers words in flight
	// A pop that lands on an empty FIFO is ignored there
	always_ff @(posedge clk) begin
		if (!reset_L)
			main_pop <= 1'b0;
		else
			main_pop <= !main_empty && !pause_vc0 && !pause_vc1;
	end

	// Returned word goes straight to both VC FIFOs
	assign vc_data = main_rd_data;

	// Route by VC bit
	assign vc_sel = main_rd_data[VC_BIT];

	// Only one push per returned word
	assign vc0_push = main_rd_valid && !vc_sel;
	assign vc1_push = main_rd_valid && vc_sel;

endmodule

//--- design/vc_arbiter.sv
// Strict-priority arbiter between the VC FIFOs
// Pops VC0 first and steers each word to D0 or D1 by its destination bit
`timescale 1ns/1ps

module vc_arbiter (
	input  logic                        clk,
	input  logic                        reset_L,
	input  logic                        vc0_empty,
	input  logic                        vc1_empty,
	input  logic [word_pkg::WORD_W-1:0] vc0_rd_data,
	input  logic                        vc0_rd_valid,
	input  logic [word_pkg::WORD_W-1:0] vc1_rd_data,
	input  logic                        vc1_rd_valid,
	input  logic                        pause_d0,
	input  logic                        pause_d1,
	output logic                        vc0_pop,
	output logic                        vc1_pop,
	output logic                        d0_push,
	output logic                        d1_push,
	output logic [word_pkg::WORD_W-1:0] dst_data
);
	import word_pkg::*;

	logic              dst_ok;
	logic              vc0_pick;
	logic              vc1_pick;
	logic [WORD_W-1:0] sel_data;
	logic              sel_valid;

	// Destination side can take a word
	assign dst_ok = !pause_d0 && !pause_d1;

	// Registered pick from the empty levels
	// VC1 only when VC0 has nothing
	always_ff @(posedge clk) begin
		if (!reset_L) begin
			vc0_pick <= 1'b0;
			vc1_pick <= 1'b0;
		end else begin
			vc0_pick <= !vc0_empty;
			vc1_pick <= vc0_empty && !vc1_empty;
		end
	end

	// Destination pause holds the pop off in the same cycle
	// Keeps at most two words in flight toward D0 and D1
	assign vc0_pop = vc0_pick && dst_ok;
	assign vc1_pop = vc1_pick && dst_ok;

	// Pops are exclusive, so at most one word returns per cycle
	assign sel_valid = vc0_rd_valid || vc1_rd_valid;
	assign sel_data  = vc0_rd_valid ? vc0_rd_data : vc1_rd_data;

	// Registered push strobes decoded on destination bit
	always_ff @(posedge clk) begin
		if (!reset_L) begin
			d0_push <= 1'b0;
			d1_push <= 1'b0;
		end else begin
			d0_push <= sel_valid && !sel_data[DST_BIT];
			d1_push <= sel_valid && sel_data[DST_BIT];
		end
	end

	// Payload register
	always_ff @(posedge clk) begin
		dst_data <= sel_data;
	end

endmodule

//--- design/link_ctrl_fsm.sv
// Link control machine
// Latches pause thresholds during init and reports idle, active and error
`timescale 1ns/1ps

module link_ctrl_fsm (
	input  logic                          clk,
	input  logic                          reset_L,
	input  logic                          init,
	input  logic [ctrl_pkg::THR_W-1:0]    thr_main_in,
	input  logic [ctrl_pkg::THR_W-1:0]    thr_vc_in,
	input  logic [ctrl_pkg::THR_W-1:0]    thr_dst_in,
	input  logic [ctrl_pkg::NUM_FIFOS-1:0] fifo_empty,
	input  logic [ctrl_pkg::NUM_FIFOS-1:0] fifo_error,
	output logic [ctrl_pkg::THR_W-1:0]    thr_main,
	output logic [ctrl_pkg::THR_W-1:0]    thr_vc,
	output logic [ctrl_pkg::THR_W-1:0]    thr_dst,
	output logic                          idle_out,
	output logic                          active_out,
	output logic                          error_out
);
	import ctrl_pkg::*;

	// Default threshold covers two words in flight
	localparam logic [THR_W-1:0] THR_RST = THR_W'(2);

	logic [ST_W-1:0] state;
	logic [ST_W-1:0] next_state;
	logic            all_empty;
	logic            any_error;

	assign all_empty = &fifo_empty;
	assign any_error = |fifo_error;

	always_comb begin
		next_state = state;
		case (state)
			ST_RESET:  next_state = init ? ST_INIT : ST_IDLE;
			ST_INIT:   if (!init) next_state = all_empty ? ST_IDLE : ST_ACTIVE;
			ST_IDLE,
			ST_ACTIVE: next_state = init ? ST_INIT : (all_empty ? ST_IDLE : ST_ACTIVE);
			ST_ERROR:  next_state = ST_ERROR;
			default:   next_state = ST_RESET;
		endcase
		// Error wins over everything once out of reset, sticky
		if (any_error && state != ST_RESET)
			next_state = ST_ERROR;
	end

	// State, flags and thresholds
	always_ff @(posedge clk) begin
		if (!reset_L) begin
			state      <= ST_RESET;
			idle_out   <= 1'b0;
			active_out <= 1'b0;
			error_out  <= 1'b0;
			thr_main   <= THR_RST;
			thr_vc     <= THR_RST;
			thr_dst    <= THR_RST;
		end else begin
			state      <= next_state;
			idle_out   <= (next_state == ST_IDLE);
			active_out <= (next_state == ST_ACTIVE);
			error_out  <= (next_state == ST_ERROR);
			// Sampled every INIT cycle
			if (state == ST_INIT) begin
				thr_main <= thr_main_in;
				thr_vc   <= thr_vc_in;
				thr_dst  <= thr_dst_in;
			end
		end
	end

endmodule

//--- design/pcie_trans.sv
// Transaction layer datapath top
// Main FIFO, two VC FIFOs, two destination FIFOs, ingress, arbiter and control
`timescale 1ns/1ps

module pcie_trans #(
	parameter int MAIN_DEPTH = 4,
	parameter int VC_DEPTH   = 16,
	parameter int DST_DEPTH  = 4
) (
	input  logic                        clk,
	input  logic                        reset_L,
	input  logic                        init,
	input  logic                        push,
	input  logic [word_pkg::WORD_W-1:0] data_in,
	input  logic                        pop_d0,
	input  logic                        pop_d1,
	input  logic [ctrl_pkg::THR_W-1:0]  thr_main,
	input  logic [ctrl_pkg::THR_W-1:0]  thr_vc,
	input  logic [ctrl_pkg::THR_W-1:0]  thr_dst,
	output logic [word_pkg::WORD_W-1:0] data_out0,
	output logic [word_pkg::WORD_W-1:0] data_out1,
	output logic                        valid_out0,
	output logic                        valid_out1,
	output logic                        pause_main,
	output logic                        active_out,
	output logic                        idle_out,
	output logic                        error_out
);
	import word_pkg::*;
	import ctrl_pkg::*;

	// Main FIFO side
	logic [WORD_W-1:0] main_rd_data;
	logic              main_rd_valid, main_pop, main_empty, main_err;
	// VC stage
	logic [WORD_W-1:0] vc_data, vc0_rd_data, vc1_rd_data;
	logic              vc0_push, vc1_push, vc0_pop, vc1_pop;
	logic              vc0_rd_valid, vc1_rd_valid, vc0_pause, vc1_pause;
	logic              vc0_empty, vc1_empty, vc0_err, vc1_err;
	// Destination stage
	logic [WORD_W-1:0] dst_data;
	logic              d0_push, d1_push, d0_pause, d1_pause;
	logic              d0_empty, d1_empty, d0_err, d1_err;
	// Latched thresholds and flag buses
	logic [THR_W-1:0]     thr_main_q, thr_vc_q, thr_dst_q;
	logic [NUM_FIFOS-1:0] fifo_empty, fifo_error;

	// Bit order main, VC0, VC1, D0, D1 from LSB
	assign fifo_empty = {d1_empty, d0_empty, vc1_empty, vc0_empty, main_empty};
	assign fifo_error = {d1_err, d0_err, vc1_err, vc0_err, main_err};

	sync_fifo #(.DEPTH(MAIN_DEPTH)) i_main_fifo (.clk(clk), .reset_L(reset_L),
		.push(push), .pop(main_pop), .wr_data(data_in), .thr(thr_main_q),
		.rd_data(main_rd_data), .rd_valid(main_rd_valid), .pause(pause_main),
		.full(), .empty(main_empty), .error(main_err));

	vc_ingress i_vc_ingress (.clk(clk), .reset_L(reset_L), .main_empty(main_empty),
		.main_rd_data(main_rd_data), .main_rd_valid(main_rd_valid),
		.pause_vc0(vc0_pause), .pause_vc1(vc1_pause), .main_pop(main_pop),
		.vc0_push(vc0_push), .vc1_push(vc1_push), .vc_data(vc_data));

	// Both VC FIFOs share thr_vc
	sync_fifo #(.DEPTH(VC_DEPTH)) i_vc0_fifo (.clk(clk), .reset_L(reset_L),
		.push(vc0_push), .pop(vc0_pop), .wr_data(vc_data), .thr(thr_vc_q),
		.rd_data(vc0_rd_data), .rd_valid(vc0_rd_valid), .pause(vc0_pause),
		.full(), .empty(vc0_empty), .error(vc0_err));

	sync_fifo #(.DEPTH(VC_DEPTH)) i_vc1_fifo (.clk(clk), .reset_L(reset_L),
		.push(vc1_push), .pop(vc1_pop), .wr_data(vc_data), .thr(thr_vc_q),
		.rd_data(vc1_rd_data), .rd_valid(vc1_rd_valid), .pause(vc1_pause),
		.full(), .empty(vc1_empty), .error(vc1_err));

	vc_arbiter i_vc_arbiter (.clk(clk), .reset_L(reset_L), .vc0_empty(vc0_empty),
		.vc1_empty(vc1_empty), .vc0_rd_data(vc0_rd_data), .vc0_rd_valid(vc0_rd_valid),
		.vc1_rd_data(vc1_rd_data), .vc1_rd_valid(vc1_rd_valid), .pause_d0(d0_pause),
		.pause_d1(d1_pause), .vc0_pop(vc0_pop), .vc1_pop(vc1_pop),
		.d0_push(d0_push), .d1_push(d1_push), .dst_data(dst_data));

	// Destination FIFOs drained by the outside, thr_dst on both
	sync_fifo #(.DEPTH(DST_DEPTH)) i_d0_fifo (.clk(clk), .reset_L(reset_L),
		.push(d0_push), .pop(pop_d0), .wr_data(dst_data), .thr(thr_dst_q),
		.rd_data(data_out0), .rd_valid(valid_out0), .pause(d0_pause),
		.full(), .empty(d0_empty), .error(d0_err));

	sync_fifo #(.DEPTH(DST_DEPTH)) i_d1_fifo (.clk(clk), .reset_L(reset_L),
		.push(d1_push), .pop(pop_d1), .wr_data(dst_data), .thr(thr_dst_q),
		.rd_data(data_out1), .rd_valid(valid_out1), .pause(d1_pause),
		.full(), .empty(d1_empty), .error(d1_err));

	link_ctrl_fsm i_link_ctrl_fsm (.clk(clk), .reset_L(reset_L), .init(init),
		.thr_main_in(thr_main), .thr_vc_in(thr_vc), .thr_dst_in(thr_dst),
		.fifo_empty(fifo_empty), .fifo_error(fifo_error),
		.thr_main(thr_main_q), .thr_vc(thr_vc_q), .thr_dst(thr_dst_q),
		.idle_out(idle_out), .active_out(active_out), .error_out(error_out));

endmodule

//--- dv/tb_pcie_trans.sv
// Testbench for the link transaction datapath
// Random traffic checked by a scoreboard and concurrent assertions
`timescale 1ns/1ps

module tb_pcie_trans;
	import word_pkg::*;
	import ctrl_pkg::*;

	// Test lengths in cycles
	// Run limit is their sum plus a margin
	localparam int LEN_RESET = 20;
	localparam int LEN_ROUTE = 300;
	localparam int LEN_BP    = 60;
	localparam int LEN_OVF   = 60;
	localparam int LEN_DRAIN = 200;
	localparam int MAX_CYC   = LEN_RESET + LEN_ROUTE + LEN_BP + LEN_OVF + 3 * LEN_DRAIN + 100;

	logic              clk, reset_L, init, push, pop_d0, pop_d1;
	logic [WORD_W-1:0] data_in, data_out0, data_out1;
	logic [THR_W-1:0]  thr_main, thr_vc, thr_dst;
	logic              valid_out0, valid_out1, pause_main, active_out, idle_out, error_out;
	logic              expect_err;
	logic [31:0]       seed = 32'h730;
	int                err_cnt = 0;
	int                cyc = 0;
	int                sb_total = 0;
	int                oldest_age = 0;
	// One queue per {VC, DST} pair
	// Entry is {push cycle, word}
	logic [31+WORD_W:0] sb[4][$];

	pcie_trans i_dut (.clk(clk), .reset_L(reset_L), .init(init), .push(push),
		.data_in(data_in), .pop_d0(pop_d0), .pop_d1(pop_d1), .thr_main(thr_main),
		.thr_vc(thr_vc), .thr_dst(thr_dst), .data_out0(data_out0), .data_out1(data_out1),
		.valid_out0(valid_out0), .valid_out1(valid_out1), .pause_main(pause_main),
		.active_out(active_out), .idle_out(idle_out), .error_out(error_out));

	always #10 clk = ~clk;

	function logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	task automatic log_error(input string msg);
		$display("ERROR @%0t: %s", $time, msg);
		err_cnt++;
	endtask

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic report_test(input string name);
		$display("test %-28s done, %0d errors so far", name, err_cnt);
	endtask

	// Pull one word off the scoreboard and compare
	task automatic check_word(input int port, input logic [WORD_W-1:0] w);
		int key;
		logic [31+WORD_W:0] e;
		key = {w[VC_BIT], w[DST_BIT]};
		if (sb[key].size() == 0) begin
			log_error($sformatf("port %0d gave %h with nothing expected", port, w));
		end else begin
			e = sb[key].pop_front();
			if (e[WORD_W-1:0] != w)
				log_error($sformatf("port %0d gave %h, expected %h", port, w, e[WORD_W-1:0]));
		end
	endtask

	// Cycle count, run limit and scoreboard
	always @(posedge clk) begin
		int oldest;
		cyc++;
		if (cyc > MAX_CYC) begin
			$display("Timeout, run went past %0d cycles", MAX_CYC);
			$display("ERRORS FOUND");
			$finish;
		end
		if (!reset_L) begin
			for (int i = 0; i < 4; i++)
				sb[i].delete();
		end else begin
			if (push && !pause_main)
				sb[{data_in[VC_BIT], data_in[DST_BIT]}].push_back({cyc[31:0], data_in});
			if (valid_out0)
				check_word(0, data_out0);
			if (valid_out1)
				check_word(1, data_out1);
		end
		sb_total = 0;
		oldest = cyc;
		for (int i = 0; i < 4; i++) begin
			sb_total += sb[i].size();
			if (sb[i].size() != 0 && int'(sb[i][0][31+WORD_W:WORD_W]) < oldest)
				oldest = int'(sb[i][0][31+WORD_W:WORD_W]);
		end
		oldest_age = cyc - oldest;
	end

	// Outputs quiet right after reset and idle shortly after
	a_reset_quiet: assert property (@(posedge clk) $rose(reset_L) |->
		!idle_out && !active_out && !error_out && !valid_out0 && !valid_out1)
		else log_error("outputs not low after reset");
	a_idle_rise: assert property (@(posedge clk) $rose(reset_L) && !init |-> ##[1:2] idle_out)
		else log_error("idle_out did not rise after reset");
	a_init_quiet: assert property (@(posedge clk) disable iff (!reset_L)
		init && $past(init) |-> !idle_out && !active_out)
		else log_error("idle_out or active_out high during init");
	// Routing by destination bit
	a_route0: assert property (@(posedge clk) disable iff (!reset_L)
		valid_out0 |-> !data_out0[DST_BIT])
		else log_error("D0 word with destination bit set");
	a_route1: assert property (@(posedge clk) disable iff (!reset_L)
		valid_out1 |-> data_out1[DST_BIT])
		else log_error("D1 word with destination bit clear");
	a_no_err: assert property (@(posedge clk) disable iff (!reset_L || expect_err) !error_out)
		else log_error("error_out high without overflow");
	// Words in flight may dip out of every FIFO for two cycles
	a_active: assert property (@(posedge clk) disable iff (!reset_L || init || expect_err)
		oldest_age > 5 |-> active_out || $past(active_out) || $past(active_out, 2)
		|| $past(active_out, 3))
		else log_error("active_out low with old words in flight");
	a_err_sticky: assert property (@(posedge clk) disable iff (!reset_L)
		error_out |=> error_out)
		else log_error("error_out dropped before reset");
	a_err_alone: assert property (@(posedge clk) error_out |-> !idle_out && !active_out)
		else log_error("idle_out or active_out high in error");

	// Pops on until the scoreboard is empty and idle returns
	task automatic drain();
		int n;
		pop_d0 = 1'b1;
		pop_d1 = 1'b1;
		n = 0;
		while (sb_total != 0 && n < LEN_DRAIN) begin
			step();
			n++;
		end
		if (sb_total != 0) begin
			$display("Drain timed out with %0d words still expected", sb_total);
			err_cnt++;
		end
		n = 0;
		while (!idle_out && n < 10) begin
			step();
			n++;
		end
		if (!idle_out)
			log_error("idle_out did not return after drain");
	endtask

	task automatic pulse_init();
		init = 1'b1;
		repeat (4) step();
		init = 1'b0;
		repeat (2) step();
	endtask

	initial begin
		logic [31:0] r;
		int n;
		clk = 1'b0;
		reset_L = 1'b0;
		init = 1'b0;
		push = 1'b0;
		data_in = '0;
		pop_d0 = 1'b0;
		pop_d1 = 1'b0;
		thr_main = 4'd2;
		thr_vc = 4'd2;
		thr_dst = 4'd2;
		expect_err = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		reset_L = 1'b1;

		repeat (3) step();
		pulse_init();
		report_test("reset and state machine");

		// Random words against random pops
		repeat (LEN_ROUTE) begin
			r = next_rand();
			push = r[31] && !pause_main;
			data_in = r[29:24];
			pop_d0 = r[20];
			pop_d1 = r[18];
			step();
		end
		push = 1'b0;
		drain();
		report_test("routing and order");

		// Stall the outputs and fill up to pause
		pulse_init();
		pop_d0 = 1'b0;
		pop_d1 = 1'b0;
		repeat (LEN_BP) begin
			r = next_rand();
			push = !pause_main;
			data_in = r[29:24];
			step();
		end
		push = 1'b0;
		if (!pause_main)
			log_error("pause_main never rose under back-pressure");
		drain();
		report_test("back-pressure");

		// Short burst goes active then idle again
		repeat (20) begin
			r = next_rand();
			push = !pause_main;
			data_in = r[29:24];
			step();
		end
		push = 1'b0;
		drain();
		report_test("active and idle");

		// Push through pause until the main FIFO overflows
		expect_err = 1'b1;
		pop_d0 = 1'b0;
		pop_d1 = 1'b0;
		repeat (LEN_OVF) begin
			r = next_rand();
			push = 1'b1;
			data_in = r[29:24];
			step();
		end
		push = 1'b0;
		n = 0;
		while (!error_out && n < 10) begin
			step();
			n++;
		end
		if (!error_out)
			log_error("error_out did not rise on overflow");
		repeat (5) step();
		reset_L = 1'b0;
		repeat (3) step();
		reset_L = 1'b1;
		expect_err = 1'b0;
		repeat (3) step();
		report_test("overflow error");

		$display("tests 5, errors %0d, cycles %0d", err_cnt, cyc);
		if (err_cnt == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- all.f
design/word_pkg.sv
design/ctrl_pkg.sv
design/sync_fifo.sv
design/vc_ingress.sv
design/vc_arbiter.sv
design/link_ctrl_fsm.sv
design/pcie_trans.sv
dv/tb_pcie_trans.sv

//--- Makefile
# Verilator build for the link datapath

LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --top-module pcie_trans -f all.f

sim:
	verilator --binary --timing --assert --top-module tb_pcie_trans -f all.f -o sim_tb
	./obj_dir/sim_tb | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
